//--- build.f
hw/dsp_width_pkg.sv
hw/dsp_ctrl_pkg.sv
hw/dsp_input_stage.sv
hw/dsp_multiplier.sv
hw/dsp_accumulator.sv
hw/dsp_output_stage.sv
hw/dsp_mac_top.sv
tests/tb_dsp_mac.sv

//--- hw/dsp_accumulator.sv
/*
 * Add/subtract and 64-bit accumulator register
 * One-cycle delay of the output controls
 */

`default_nettype none

module dsp_accumulator (
    input  wire                      clock_i,
    input  wire                      s_reset,
    input  dsp_width_pkg::acc_t      product_i,
    input  dsp_ctrl_pkg::feedback_t  feedback_i,
    input  wire                      load_acc_i,
    input  wire                      subtract_i,
    input  wire                      unsigned_mode_i,
    input  dsp_ctrl_pkg::shift_t     shift_right_i,
    input  wire                      round_i,
    input  wire                      saturate_enable_i,
    output dsp_width_pkg::acc_t      acc_o,
    output logic                     unsigned_mode_o,
    output dsp_ctrl_pkg::shift_t     shift_right_o,
    output logic                     round_o,
    output logic                     saturate_enable_o
);

    dsp_width_pkg::acc_t add_a;
    dsp_width_pkg::acc_t add_b;
    dsp_width_pkg::acc_t sum;

    assign add_a = subtract_i ? -product_i : product_i;

    // Reserved codes 2 and 3 fall to the accumulate case
    always_comb begin
        case (feedback_i)
            dsp_ctrl_pkg::FB_PRODUCT_ONLY: add_b = '0;
            default:                       add_b = acc_o;
        endcase
    end

    assign sum = add_a + add_b;

    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            acc_o <= '0;
        end else if (load_acc_i) begin
            acc_o <= sum;
        end
    end

    // Controls leave together with the value they apply to
    always_ff @(posedge clock_i or posedge s_reset) begin
        if (s_reset) begin
            unsigned_mode_o   <= 1'b0;
            shift_right_o     <= '0;
            round_o           <= 1'b0;
            saturate_enable_o <= 1'b0;
        end else begin
            unsigned_mode_o   <= unsigned_mode_i;
            shift_right_o     <= shift_right_i;
            round_o           <= round_i;
            saturate_enable_o <= saturate_enable_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/dsp_ctrl_pkg.sv
/*
 * Control field types of the MAC slice
 * Feedback source codes
 */

`default_nettype none

package dsp_ctrl_pkg;

    // Multiplier and adder source select
    typedef logic [2:0] feedback_t;

    // Right shift amount applied to the accumulator
    typedef logic [5:0] shift_t;

    // Adder takes the accumulator
    localparam feedback_t FB_ACCUMULATE = 3'd0;

    // Adder takes zero, so z shows the product alone
    localparam feedback_t FB_PRODUCT_ONLY = 3'd1;

    // Codes 4 to 7 pick coefficient 0 to 3 in place of a
    localparam feedback_t FB_COEFF_BASE = 3'd4;

endpackage

`default_nettype wire

//--- hw/dsp_input_stage.sv
/*
 * Optional input register of operands and controls
 */

`default_nettype none

module dsp_input_stage #(
    parameter bit REGISTER_INPUTS = 1'b1
) (
    input  wire                          clock_i,
    input  wire                          s_reset,
    input  dsp_width_pkg::operand_a_t    a_i,
    input  dsp_width_pkg::operand_b_t    b_i,
    input  dsp_ctrl_pkg::feedback_t      feedback_i,
    input  wire                          load_acc_i,
    input  wire                          subtract_i,
    input  wire                          unsigned_a_i,
    input  wire                          unsigned_b_i,
    input  dsp_ctrl_pkg::shift_t         shift_right_i,
    input  wire                          round_i,
    input  wire                          saturate_enable_i,
    output dsp_width_pkg::operand_a_t    a_o,
    output dsp_width_pkg::operand_b_t    b_o,
    output dsp_ctrl_pkg::feedback_t      feedback_o,
    output logic                         load_acc_o,
    output logic                         subtract_o,
    output logic                         unsigned_a_o,
    output logic                         unsigned_b_o,
    output dsp_ctrl_pkg::shift_t         shift_right_o,
    output logic                         round_o,
    output logic                         saturate_enable_o
);

    generate
        if (REGISTER_INPUTS) begin : g_reg
            always_ff @(posedge clock_i or posedge s_reset) begin
                if (s_reset) begin
                    a_o               <= '0;
                    b_o               <= '0;
                    feedback_o        <= dsp_ctrl_pkg::FB_ACCUMULATE;
                    load_acc_o        <= 1'b0;
                    subtract_o        <= 1'b0;
                    unsigned_a_o      <= 1'b0;
                    unsigned_b_o      <= 1'b0;
                    shift_right_o     <= '0;
                    round_o           <= 1'b0;
                    saturate_enable_o <= 1'b0;
                end else begin
                    a_o               <= a_i;
                    b_o               <= b_i;
                    feedback_o        <= feedback_i;
                    load_acc_o        <= load_acc_i;
                    subtract_o        <= subtract_i;
                    unsigned_a_o      <= unsigned_a_i;
                    unsigned_b_o      <= unsigned_b_i;
                    shift_right_o     <= shift_right_i;
                    round_o           <= round_i;
                    saturate_enable_o <= saturate_enable_i;
                end
            end
        end else begin : g_bypass
            // Zero-latency path
            assign a_o               = a_i;
            assign b_o               = b_i;
            assign feedback_o        = feedback_i;
            assign load_acc_o        = load_acc_i;
            assign subtract_o        = subtract_i;
            assign unsigned_a_o      = unsigned_a_i;
            assign unsigned_b_o      = unsigned_b_i;
            assign shift_right_o     = shift_right_i;
            assign round_o           = round_i;
            assign saturate_enable_o = saturate_enable_i;
        end
    endgenerate

endmodule

`default_nettype wire

//--- hw/dsp_mac_top.sv
/*
 * MAC slice top level, input stage to output stage
 */

`default_nettype none

module dsp_mac_top #(
    parameter bit                        REGISTER_INPUTS = 1'b1,
    parameter bit                        REGISTER_OUTPUT = 1'b1,
    parameter dsp_width_pkg::operand_a_t COEFF_0 = '0,
    parameter dsp_width_pkg::operand_a_t COEFF_1 = '0,
    parameter dsp_width_pkg::operand_a_t COEFF_2 = '0,
    parameter dsp_width_pkg::operand_a_t COEFF_3 = '0
) (
    input  wire                          clock_i,
    input  wire                          s_reset,
    input  dsp_width_pkg::operand_a_t    a_i,
    input  dsp_width_pkg::operand_b_t    b_i,
    input  dsp_ctrl_pkg::feedback_t      feedback_i,
    input  wire                          load_acc_i,
    input  wire                          subtract_i,
    input  wire                          unsigned_a_i,
    input  wire                          unsigned_b_i,
    input  dsp_ctrl_pkg::shift_t         shift_right_i,
    input  wire                          round_i,
    input  wire                          saturate_enable_i,
    output dsp_width_pkg::result_t       z_o
);

    // Staged inputs
    dsp_width_pkg::operand_a_t s_a;
    dsp_width_pkg::operand_b_t s_b;
    dsp_ctrl_pkg::feedback_t   s_feedback;
    logic                      s_load_acc;
    logic                      s_subtract;
    logic                      s_unsigned_a;
    logic                      s_unsigned_b;
    dsp_ctrl_pkg::shift_t      s_shift_right;
    logic                      s_round;
    logic                      s_saturate_enable;

    dsp_width_pkg::acc_t       product;
    logic                      unsigned_mode;

    // Accumulator value and its aligned controls
    dsp_width_pkg::acc_t       acc;
    logic                      d_unsigned_mode;
    dsp_ctrl_pkg::shift_t      d_shift_right;
    logic                      d_round;
    logic                      d_saturate_enable;

    dsp_input_stage #(
        .REGISTER_INPUTS(REGISTER_INPUTS)
    ) u_input_stage (
        .clock_i(clock_i),
        .s_reset(s_reset),
        .a_i(a_i),
        .b_i(b_i),
        .feedback_i(feedback_i),
        .load_acc_i(load_acc_i),
        .subtract_i(subtract_i),
        .unsigned_a_i(unsigned_a_i),
        .unsigned_b_i(unsigned_b_i),
        .shift_right_i(shift_right_i),
        .round_i(round_i),
        .saturate_enable_i(saturate_enable_i),
        .a_o(s_a),
        .b_o(s_b),
        .feedback_o(s_feedback),
        .load_acc_o(s_load_acc),
        .subtract_o(s_subtract),
        .unsigned_a_o(s_unsigned_a),
        .unsigned_b_o(s_unsigned_b),
        .shift_right_o(s_shift_right),
        .round_o(s_round),
        .saturate_enable_o(s_saturate_enable)
    );

    dsp_multiplier #(
        .COEFF_0(COEFF_0),
        .COEFF_1(COEFF_1),
        .COEFF_2(COEFF_2),
        .COEFF_3(COEFF_3)
    ) u_multiplier (
        .a_i(s_a),
        .b_i(s_b),
        .feedback_i(s_feedback),
        .unsigned_a_i(s_unsigned_a),
        .unsigned_b_i(s_unsigned_b),
        .product_o(product),
        .unsigned_mode_o(unsigned_mode)
    );

    dsp_accumulator u_accumulator (
        .clock_i(clock_i),
        .s_reset(s_reset),
        .product_i(product),
        .feedback_i(s_feedback),
        .load_acc_i(s_load_acc),
        .subtract_i(s_subtract),
        .unsigned_mode_i(unsigned_mode),
        .shift_right_i(s_shift_right),
        .round_i(s_round),
        .saturate_enable_i(s_saturate_enable),
        .acc_o(acc),
        .unsigned_mode_o(d_unsigned_mode),
        .shift_right_o(d_shift_right),
        .round_o(d_round),
        .saturate_enable_o(d_saturate_enable)
    );

    dsp_output_stage #(
        .REGISTER_OUTPUT(REGISTER_OUTPUT)
    ) u_output_stage (
        .clock_i(clock_i),
        .s_reset(s_reset),
        .acc_i(acc),
        .unsigned_mode_i(d_unsigned_mode),
        .shift_right_i(d_shift_right),
        .round_i(d_round),
        .saturate_enable_i(d_saturate_enable),
        .z_o(z_o)
    );

endmodule

`default_nettype wire

//--- hw/dsp_multiplier.sv
/*
 * Operand select and sign-magnitude multiplier
 * Extends the product to accumulator width
 */

`default_nettype none

module dsp_multiplier #(
    parameter dsp_width_pkg::operand_a_t COEFF_0 = '0,
    parameter dsp_width_pkg::operand_a_t COEFF_1 = '0,
    parameter dsp_width_pkg::operand_a_t COEFF_2 = '0,
    parameter dsp_width_pkg::operand_a_t COEFF_3 = '0
) (
    input  dsp_width_pkg::operand_a_t    a_i,
    input  dsp_width_pkg::operand_b_t    b_i,
    input  dsp_ctrl_pkg::feedback_t      feedback_i,
    input  wire                          unsigned_a_i,
    input  wire                          unsigned_b_i,
    output dsp_width_pkg::acc_t          product_o,
    output logic                         unsigned_mode_o
);

    localparam int EXT_WIDTH = dsp_width_pkg::ACC_WIDTH - dsp_width_pkg::PROD_WIDTH;

    dsp_width_pkg::operand_a_t           sel_a;
    dsp_width_pkg::operand_a_t           mag_a;
    dsp_width_pkg::operand_b_t           mag_b;
    logic                                neg_a;
    logic                                neg_b;
    logic [dsp_width_pkg::PROD_WIDTH-1:0] prod_mag;
    logic [dsp_width_pkg::PROD_WIDTH-1:0] prod;
    logic                                ext_bit;

    // Coefficient index comes from the low two bits of codes 4 to 7
    always_comb begin
        sel_a = a_i;
        if (feedback_i >= dsp_ctrl_pkg::FB_COEFF_BASE) begin
            case (feedback_i[1:0])
                2'd0:    sel_a = COEFF_0;
                2'd1:    sel_a = COEFF_1;
                2'd2:    sel_a = COEFF_2;
                default: sel_a = COEFF_3;
            endcase
        end
    end

    assign neg_a = sel_a[dsp_width_pkg::A_WIDTH-1] & ~unsigned_a_i;
    assign neg_b = b_i[dsp_width_pkg::B_WIDTH-1] & ~unsigned_b_i;
    assign mag_a = neg_a ? -sel_a : sel_a;
    assign mag_b = neg_b ? -b_i : b_i;

    assign prod_mag = {{dsp_width_pkg::B_WIDTH{1'b0}}, mag_a}
                    * {{dsp_width_pkg::A_WIDTH{1'b0}}, mag_b};
    assign prod     = (neg_a ^ neg_b) ? -prod_mag : prod_mag;

    // Zero extension only when both operands are unsigned
    assign unsigned_mode_o = unsigned_a_i & unsigned_b_i;
    assign ext_bit         = ~unsigned_mode_o & prod[dsp_width_pkg::PROD_WIDTH-1];
    assign product_o       = {{EXT_WIDTH{ext_bit}}, prod};

endmodule

`default_nettype wire

//--- hw/dsp_output_stage.sv
/*
 * Shift, round and saturate of the accumulator value
 * Optional output register
 */

`default_nettype none

module dsp_output_stage #(
    parameter bit REGISTER_OUTPUT = 1'b1
) (
    input  wire                      clock_i,
    input  wire                      s_reset,
    input  dsp_width_pkg::acc_t      acc_i,
    input  wire                      unsigned_mode_i,
    input  dsp_ctrl_pkg::shift_t     shift_right_i,
    input  wire                      round_i,
    input  wire                      saturate_enable_i,
    output dsp_width_pkg::result_t   z_o
);

    localparam int ACC_W = dsp_width_pkg::ACC_WIDTH;
    localparam int Z_W   = dsp_width_pkg::Z_WIDTH;

    dsp_width_pkg::acc_t    acc_shr;
    dsp_width_pkg::acc_t    acc_rnd;
    dsp_width_pkg::acc_t    acc_sat;
    dsp_width_pkg::result_t z_comb;
    logic                   round_bit;
    logic                   sign_ok;

    assign acc_shr = $signed(acc_i) >>> shift_right_i;

    // Last bit shifted out
    assign round_bit = round_i && (shift_right_i != '0)
                     && acc_i[shift_right_i - 6'd1];
    assign acc_rnd   = acc_shr + {{(ACC_W-1){1'b0}}, round_bit};

    // Upper bits all equal means the value fits in Z_W signed bits
    assign sign_ok = (&acc_rnd[ACC_W-1:Z_W-1]) | ~(|acc_rnd[ACC_W-1:Z_W-1]);

    always_comb begin
        acc_sat = acc_rnd;
        if (saturate_enable_i) begin
            if (unsigned_mode_i) begin
                if (acc_rnd[ACC_W-1]) begin
                    acc_sat = '0;
                end else if (|acc_rnd[ACC_W-1:Z_W]) begin
                    acc_sat = {{(ACC_W-Z_W){1'b0}}, {Z_W{1'b1}}};
                end
            end else if (!sign_ok) begin
                // Clamp to -2^37 or 2^37-1
                if (acc_rnd[ACC_W-1]) begin
                    acc_sat = {{(ACC_W-Z_W+1){1'b1}}, {(Z_W-1){1'b0}}};
                end else begin
                    acc_sat = {{(ACC_W-Z_W+1){1'b0}}, {(Z_W-1){1'b1}}};
                end
            end
        end
    end

    assign z_comb = acc_sat[Z_W-1:0];

    generate
        if (REGISTER_OUTPUT) begin : g_reg
            always_ff @(posedge clock_i or posedge s_reset) begin
                if (s_reset) begin
                    z_o <= '0;
                end else begin
                    z_o <= z_comb;
                end
            end
        end else begin : g_bypass
            assign z_o = z_comb;
        end
    endgenerate

endmodule

`default_nettype wire

//--- hw/dsp_width_pkg.sv
/*
 * Data path widths of the MAC slice
 * Operand, product, accumulator and result vector types
 */

`default_nettype none

package dsp_width_pkg;

    // Operand a and the four coefficients
    localparam int A_WIDTH = 20;

    localparam int B_WIDTH = 18;

    // Full product of a and b
    localparam int PROD_WIDTH = A_WIDTH + B_WIDTH;

    localparam int ACC_WIDTH = 64;

    // Width of z
    localparam int Z_WIDTH = 38;

    typedef logic [A_WIDTH-1:0]   operand_a_t;
    typedef logic [B_WIDTH-1:0]   operand_b_t;
    typedef logic [ACC_WIDTH-1:0] acc_t;
    typedef logic [Z_WIDTH-1:0]   result_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module tb_dsp_mac
output=$(./obj_dir/Vtb_dsp_mac)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

//--- tests/tb_dsp_mac.sv
/*
 * Testbench of the MAC slice with a stimulus table of expected z
 * Clock and reset, result checks and run timeout
 */

`default_nettype none

module tb_dsp_mac;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 3;
    // One cycle each for input register, accumulator and output register
    localparam int LATENCY      = 3;
    localparam int MARGIN       = 20;

    localparam dsp_width_pkg::operand_a_t COEFF_0 = 20'd3;
    localparam dsp_width_pkg::operand_a_t COEFF_1 = 20'hFFFFB;
    localparam dsp_width_pkg::operand_a_t COEFF_2 = 20'd100;
    localparam dsp_width_pkg::operand_a_t COEFF_3 = 20'h7FFFF;

    typedef struct packed {
        dsp_width_pkg::operand_a_t a;
        dsp_width_pkg::operand_b_t b;
        dsp_ctrl_pkg::feedback_t   feedback;
        dsp_width_pkg::result_t    expected;
        logic                      load_acc;
        logic                      subtract;
        logic                      unsigned_a;
        logic                      unsigned_b;
        dsp_ctrl_pkg::shift_t      shift_right;
        logic                      rnd;
        logic                      sat;
    } row_t;

    logic                      clock_i = 1'b0;
    logic                      s_reset;
    dsp_width_pkg::operand_a_t a_i;
    dsp_width_pkg::operand_b_t b_i;
    dsp_ctrl_pkg::feedback_t   feedback_i;
    logic                      load_acc_i;
    logic                      subtract_i;
    logic                      unsigned_a_i;
    logic                      unsigned_b_i;
    dsp_ctrl_pkg::shift_t      shift_right_i;
    logic                      round_i;
    logic                      saturate_enable_i;
    dsp_width_pkg::result_t    z_o;

    row_t rows[$];
    int   error_count   = 0;
    int   check_count   = 0;
    int   cycle_count   = 0;
    int   timeout_limit = 0;

    dsp_mac_top #(
        .REGISTER_INPUTS(1'b1),
        .REGISTER_OUTPUT(1'b1),
        .COEFF_0(COEFF_0),
        .COEFF_1(COEFF_1),
        .COEFF_2(COEFF_2),
        .COEFF_3(COEFF_3)
    ) DUT (
        .clock_i(clock_i),
        .s_reset(s_reset),
        .a_i(a_i),
        .b_i(b_i),
        .feedback_i(feedback_i),
        .load_acc_i(load_acc_i),
        .subtract_i(subtract_i),
        .unsigned_a_i(unsigned_a_i),
        .unsigned_b_i(unsigned_b_i),
        .shift_right_i(shift_right_i),
        .round_i(round_i),
        .saturate_enable_i(saturate_enable_i),
        .z_o(z_o)
    );

    always #5 clock_i = ~clock_i;

    always @(posedge clock_i) begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic void add_row(
        input dsp_width_pkg::operand_a_t a,
        input dsp_width_pkg::operand_b_t b,
        input dsp_ctrl_pkg::feedback_t   fb,
        input dsp_width_pkg::result_t    expected,
        input logic                      load,
        input logic                      sub,
        input logic                      ua,
        input logic                      ub,
        input dsp_ctrl_pkg::shift_t      shift,
        input logic                      rnd,
        input logic                      sat
    );
        row_t r;
        r = '{a, b, fb, expected, load, sub, ua, ub, shift, rnd, sat};
        rows.push_back(r);
    endfunction

    task automatic check_value(input string name, input dsp_width_pkg::result_t got,
                               input dsp_width_pkg::result_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
        end
    endtask

    task automatic apply_row(input row_t r);
        a_i               <= r.a;
        b_i               <= r.b;
        feedback_i        <= r.feedback;
        load_acc_i        <= r.load_acc;
        subtract_i        <= r.subtract;
        unsigned_a_i      <= r.unsigned_a;
        unsigned_b_i      <= r.unsigned_b;
        shift_right_i     <= r.shift_right;
        round_i           <= r.rnd;
        saturate_enable_i <= r.sat;
    endtask

    // Expected z values worked out by hand in 38-bit two's complement
    task automatic build_table();
        // Product only with code 1
        add_row(20'h00000, 18'h00000, 3'd1, 38'h00_0000_0000,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'hFFFFD, 18'h00007, 3'd1, 38'h3F_FFFF_FFEB,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'hFFFFF, 18'h3FFFF, 3'd1, 38'h3F_FFFC_0001,
                1'b1, 1'b0, 1'b0, 1'b1, 6'd0, 1'b0, 1'b0);
        add_row(20'hFFFFF, 18'h3FFFF, 3'd1, 38'h3F_FFEC_0001,
                1'b1, 1'b0, 1'b1, 1'b1, 6'd0, 1'b0, 1'b0);
        add_row(20'h80000, 18'h3FFFE, 3'd1, 38'h3F_FFF0_0000,
                1'b1, 1'b0, 1'b1, 1'b0, 6'd0, 1'b0, 1'b0);
        // Accumulate, subtract, hold, restart
        add_row(20'h00064, 18'h0000A, 3'd1, 38'h00_0000_03E8,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'h000C8, 18'h00005, 3'd0, 38'h00_0000_07D0,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'hFFFF9, 18'h00003, 3'd0, 38'h00_0000_07BB,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'h00032, 18'h00004, 3'd0, 38'h00_0000_06F3,
                1'b1, 1'b1, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'h003E7, 18'h003E7, 3'd0, 38'h00_0000_06F3,
                1'b0, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'h00006, 18'h00007, 3'd1, 38'h00_0000_002A,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        // Coefficients 3, -5, 100 and 0x7FFFF plus the accumulator
        add_row(20'h00000, 18'h0000A, 3'd4, 38'h00_0000_0048,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'h00000, 18'h0000A, 3'd5, 38'h00_0000_0016,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'h00000, 18'h3FFFE, 3'd6, 38'h3F_FFFF_FF4E,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'h00000, 18'h00002, 3'd7, 38'h00_000F_FF4C,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        // 0x1238 shifted by 4 as floor and then rounded up
        add_row(20'h01230, 18'h00001, 3'd1, 38'h00_0000_1230,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b0);
        add_row(20'h00008, 18'h00001, 3'd0, 38'h00_0000_0123,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd4, 1'b0, 1'b0);
        add_row(20'h00000, 18'h00000, 3'd0, 38'h00_0000_0124,
                1'b0, 1'b0, 1'b0, 1'b0, 6'd4, 1'b1, 1'b0);
        // Signed saturation in steps of 2^36
        add_row(20'h80000, 18'h20000, 3'd1, 38'h10_0000_0000,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b1);
        add_row(20'h80000, 18'h20000, 3'd0, 38'h1F_FFFF_FFFF,
                1'b1, 1'b0, 1'b0, 1'b0, 6'd0, 1'b0, 1'b1);
        add_row(20'h80000, 18'h20000, 3'd1, 38'h30_0000_0000,
                1'b1, 1'b1, 1'b0, 1'b0, 6'd0, 1'b0, 1'b1);
        add_row(20'h80000, 18'h20000, 3'd0, 38'h20_0000_0000,
                1'b1, 1'b1, 1'b0, 1'b0, 6'd0, 1'b0, 1'b1);
        add_row(20'h00001, 18'h00001, 3'd0, 38'h20_0000_0000,
                1'b1, 1'b1, 1'b0, 1'b0, 6'd0, 1'b0, 1'b1);
        // Unsigned saturation and then the same total unclamped
        add_row(20'hFFFFF, 18'h3FFFF, 3'd1, 38'h3F_FFEC_0001,
                1'b1, 1'b0, 1'b1, 1'b1, 6'd0, 1'b0, 1'b1);
        add_row(20'hFFFFF, 18'h3FFFF, 3'd0, 38'h3F_FFFF_FFFF,
                1'b1, 1'b0, 1'b1, 1'b1, 6'd0, 1'b0, 1'b1);
        add_row(20'hFFFFF, 18'h3FFFF, 3'd0, 38'h3F_FFD8_0002,
                1'b0, 1'b0, 1'b1, 1'b1, 6'd0, 1'b0, 1'b0);
        // Negative total in unsigned mode clamps to zero
        add_row(20'h00005, 18'h00005, 3'd1, 38'h00_0000_0000,
                1'b1, 1'b1, 1'b1, 1'b1, 6'd0, 1'b0, 1'b1);
    endtask

    initial begin
        build_table();
        timeout_limit = rows.size() + RESET_CYCLES + LATENCY + MARGIN;

        s_reset           = 1'b1;
        a_i               = '0;
        b_i               = '0;
        feedback_i        = '0;
        load_acc_i        = 1'b0;
        subtract_i        = 1'b0;
        unsigned_a_i      = 1'b0;
        unsigned_b_i      = 1'b0;
        shift_right_i     = '0;
        round_i           = 1'b0;
        saturate_enable_i = 1'b0;

        repeat (RESET_CYCLES - 1) begin
            @(posedge clock_i);
            @(negedge clock_i);
            check_value("z_o", z_o, '0);
        end
        @(posedge clock_i);
        s_reset <= 1'b0;

        // Each row comes out LATENCY cycles after it is driven
        for (int idx = 0; idx < rows.size() + LATENCY; idx++) begin
            @(posedge clock_i);
            if (idx < rows.size()) begin
                apply_row(rows[idx]);
            end else begin
                load_acc_i <= 1'b0;
            end
            @(negedge clock_i);
            if (idx >= LATENCY) begin
                check_value("z_o", z_o, rows[idx - LATENCY].expected);
            end else begin
                check_value("z_o", z_o, '0);
            end
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
